// File: include/id_stage_cfg.svh
`ifndef ID_STAGE_CFG_SVH
`define ID_STAGE_CFG_SVH

`define ID_DATA_WIDTH      32
`define ID_REG_ADDR_WIDTH  5
`define ID_INST_WIDTH      32
`define ID_ALUOP_WIDTH     8
`define ID_ALUSEL_WIDTH    3

// the primary opcode sits in bits 31..26.
`define ID_OP_SPECIAL  6'b000000
`define ID_OP_ORI      6'b001101
`define ID_OP_ANDI     6'b001100
`define ID_OP_XORI     6'b001110
`define ID_OP_LUI      6'b001111
`define ID_OP_SLTI     6'b001010
`define ID_OP_SLTIU    6'b001011
`define ID_OP_ADDI     6'b001000
`define ID_OP_ADDIU    6'b001001

// the function field of SPECIAL sits in bits 5..0.
`define ID_FN_OR    6'b100101
`define ID_FN_AND   6'b100100
`define ID_FN_XOR   6'b100110
`define ID_FN_NOR   6'b100111
`define ID_FN_SLL   6'b000000
`define ID_FN_SRL   6'b000010
`define ID_FN_SRA   6'b000011
`define ID_FN_SLLV  6'b000100
`define ID_FN_SRLV  6'b000110
`define ID_FN_SRAV  6'b000111
`define ID_FN_SLT   6'b101010
`define ID_FN_SLTU  6'b101011
`define ID_FN_ADD   6'b100000
`define ID_FN_ADDU  6'b100001
`define ID_FN_SUB   6'b100010
`define ID_FN_SUBU  6'b100011

`define ID_ALUOP_NOP    8'b00000000
`define ID_ALUOP_OR     8'b00100101
`define ID_ALUOP_AND    8'b00100100
`define ID_ALUOP_XOR    8'b00100110
`define ID_ALUOP_NOR    8'b00100111
`define ID_ALUOP_SLL    8'b01111100
`define ID_ALUOP_SRL    8'b00000010
`define ID_ALUOP_SRA    8'b00000011
`define ID_ALUOP_SLT    8'b00101010
`define ID_ALUOP_SLTU   8'b00101011
`define ID_ALUOP_ADD    8'b00100000
`define ID_ALUOP_ADDU   8'b00100001
`define ID_ALUOP_SUB    8'b00100010
`define ID_ALUOP_SUBU   8'b00100011
`define ID_ALUOP_ADDI   8'b01010101
`define ID_ALUOP_ADDIU  8'b01010110

`define ID_ALUSEL_NOP         3'b000
`define ID_ALUSEL_LOGIC       3'b001
`define ID_ALUSEL_SHIFT       3'b010
`define ID_ALUSEL_ARITHMETIC  3'b100

`endif

// File: design/id_stage_pkg.sv
`default_nettype none

`include "id_stage_cfg.svh"

package id_stage_pkg;

    typedef logic [`ID_INST_WIDTH-1:0]     inst_t;
    typedef logic [`ID_DATA_WIDTH-1:0]     data_t;
    typedef logic [`ID_REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [`ID_ALUOP_WIDTH-1:0]    aluop_t;
    typedef logic [`ID_ALUSEL_WIDTH-1:0]   alusel_t;

    // a register write serves the write-back port and both forward paths.
    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        data_t     data;
    } reg_write_t;

    typedef struct packed {
        logic      rd_en1;
        logic      rd_en2;
        reg_addr_t rd_addr1;
        reg_addr_t rd_addr2;
        logic      wr_en;
        reg_addr_t wr_addr;
        data_t     imm;
        aluop_t    aluop;
        alusel_t   alusel;
    } decoded_t;

    typedef struct packed {
        aluop_t    aluop;
        alusel_t   alusel;
        data_t     operand1;
        data_t     operand2;
        logic      wr_en;
        reg_addr_t wr_addr;
    } id_ex_t;

endpackage

`default_nettype wire

// File: design/id_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_stage_cfg.svh"

module id_decoder
    import id_stage_pkg::*;
(
    input  inst_t    inst,
    output decoded_t dec
);

    logic [5:0]  opcode;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [4:0]  shamt;
    logic [5:0]  funct;
    logic [15:0] im;

    aluop_t  fn_aluop;
    alusel_t fn_alusel;
    logic    fn_valid;
    logic    fn_shamt;
    logic    imm_form;

    assign opcode = inst[31:26];
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign shamt  = inst[10:6];
    assign funct  = inst[5:0];
    assign im     = inst[15:0];

    // the three shifts by constant take their amount from the shamt field.
    assign fn_shamt = (funct == `ID_FN_SLL) || (funct == `ID_FN_SRL) || (funct == `ID_FN_SRA);

    always_comb begin
        fn_valid = 1'b1;
        {fn_aluop, fn_alusel} = {`ID_ALUOP_NOP, `ID_ALUSEL_NOP};
        case (funct)
            `ID_FN_OR:   {fn_aluop, fn_alusel} = {`ID_ALUOP_OR, `ID_ALUSEL_LOGIC};
            `ID_FN_AND:  {fn_aluop, fn_alusel} = {`ID_ALUOP_AND, `ID_ALUSEL_LOGIC};
            `ID_FN_XOR:  {fn_aluop, fn_alusel} = {`ID_ALUOP_XOR, `ID_ALUSEL_LOGIC};
            `ID_FN_NOR:  {fn_aluop, fn_alusel} = {`ID_ALUOP_NOR, `ID_ALUSEL_LOGIC};
            `ID_FN_SLL:  {fn_aluop, fn_alusel} = {`ID_ALUOP_SLL, `ID_ALUSEL_SHIFT};
            `ID_FN_SRL:  {fn_aluop, fn_alusel} = {`ID_ALUOP_SRL, `ID_ALUSEL_SHIFT};
            `ID_FN_SRA:  {fn_aluop, fn_alusel} = {`ID_ALUOP_SRA, `ID_ALUSEL_SHIFT};
            `ID_FN_SLLV: {fn_aluop, fn_alusel} = {`ID_ALUOP_SLL, `ID_ALUSEL_SHIFT};
            `ID_FN_SRLV: {fn_aluop, fn_alusel} = {`ID_ALUOP_SRL, `ID_ALUSEL_SHIFT};
            `ID_FN_SRAV: {fn_aluop, fn_alusel} = {`ID_ALUOP_SRA, `ID_ALUSEL_SHIFT};
            `ID_FN_SLT:  {fn_aluop, fn_alusel} = {`ID_ALUOP_SLT, `ID_ALUSEL_ARITHMETIC};
            `ID_FN_SLTU: {fn_aluop, fn_alusel} = {`ID_ALUOP_SLTU, `ID_ALUSEL_ARITHMETIC};
            `ID_FN_ADD:  {fn_aluop, fn_alusel} = {`ID_ALUOP_ADD, `ID_ALUSEL_ARITHMETIC};
            `ID_FN_ADDU: {fn_aluop, fn_alusel} = {`ID_ALUOP_ADDU, `ID_ALUSEL_ARITHMETIC};
            `ID_FN_SUB:  {fn_aluop, fn_alusel} = {`ID_ALUOP_SUB, `ID_ALUSEL_ARITHMETIC};
            `ID_FN_SUBU: {fn_aluop, fn_alusel} = {`ID_ALUOP_SUBU, `ID_ALUSEL_ARITHMETIC};
            default:     fn_valid = 1'b0;
        endcase
    end

    always_comb begin
        dec          = '0;
        dec.rd_addr1 = rs;
        dec.rd_addr2 = rt;
        dec.aluop    = `ID_ALUOP_NOP;
        dec.alusel   = `ID_ALUSEL_NOP;
        imm_form     = 1'b1;
        case (opcode)
            `ID_OP_SPECIAL: begin
                imm_form = 1'b0;
                // constant shifts need rs zero, every other register form needs shamt zero.
                if (fn_valid && (fn_shamt ? (rs == '0) : (shamt == '0))) begin
                    dec.aluop   = fn_aluop;
                    dec.alusel  = fn_alusel;
                    dec.rd_en1  = !fn_shamt;
                    dec.rd_en2  = 1'b1;
                    dec.wr_en   = 1'b1;
                    dec.wr_addr = rd;
                    dec.imm     = fn_shamt ? data_t'(shamt) : '0;
                end
            end
            `ID_OP_ORI: begin
                {dec.aluop, dec.alusel} = {`ID_ALUOP_OR, `ID_ALUSEL_LOGIC};
                dec.imm = data_t'(im);
            end
            `ID_OP_ANDI: begin
                {dec.aluop, dec.alusel} = {`ID_ALUOP_AND, `ID_ALUSEL_LOGIC};
                dec.imm = data_t'(im);
            end
            `ID_OP_XORI: begin
                {dec.aluop, dec.alusel} = {`ID_ALUOP_XOR, `ID_ALUSEL_LOGIC};
                dec.imm = data_t'(im);
            end
            `ID_OP_LUI: begin
                {dec.aluop, dec.alusel} = {`ID_ALUOP_OR, `ID_ALUSEL_LOGIC};
                dec.imm = {im, 16'h0000};
            end
            `ID_OP_SLTI: begin
                {dec.aluop, dec.alusel} = {`ID_ALUOP_SLT, `ID_ALUSEL_ARITHMETIC};
                dec.imm = {{16{im[15]}}, im};
            end
            `ID_OP_SLTIU: begin
                {dec.aluop, dec.alusel} = {`ID_ALUOP_SLTU, `ID_ALUSEL_ARITHMETIC};
                dec.imm = {{16{im[15]}}, im};
            end
            `ID_OP_ADDI: begin
                {dec.aluop, dec.alusel} = {`ID_ALUOP_ADDI, `ID_ALUSEL_ARITHMETIC};
                dec.imm = {{16{im[15]}}, im};
            end
            `ID_OP_ADDIU: begin
                {dec.aluop, dec.alusel} = {`ID_ALUOP_ADDIU, `ID_ALUSEL_ARITHMETIC};
                dec.imm = {{16{im[15]}}, im};
            end
            default: imm_form = 1'b0;
        endcase

        // immediate forms all read rs and write rt.
        if (imm_form) begin
            dec.rd_en1  = 1'b1;
            dec.wr_en   = 1'b1;
            dec.wr_addr = rt;
        end
    end

endmodule

`default_nettype wire

// File: design/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward
    import id_stage_pkg::*;
(
    input  logic       rd_en,
    input  reg_addr_t  rd_addr,
    input  data_t      imm,
    input  data_t      rf_data,
    input  reg_write_t ex_fwd,
    input  reg_write_t mem_fwd,
    output data_t      operand
);

    // register 0 is hard wired, so a result aimed at it is never forwarded.
    function automatic logic fwd_hit(reg_write_t fwd, reg_addr_t addr);
        return fwd.en && (fwd.addr != '0) && (fwd.addr == addr);
    endfunction

    always_comb begin
        if (!rd_en) begin
            operand = imm;
        end else if (fwd_hit(ex_fwd, rd_addr)) begin
            operand = ex_fwd.data;
        end else if (fwd_hit(mem_fwd, rd_addr)) begin
            operand = mem_fwd.data;
        end else begin
            operand = rf_data;
        end
    end

endmodule

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import id_stage_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  reg_addr_t  rd_addr1,
    input  reg_addr_t  rd_addr2,
    output data_t      rd_data1,
    output data_t      rd_data2,
    input  reg_write_t wr
);

    // register 0 has no storage.
    data_t regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && (wr.addr != '0)) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // a read of the register being written returns the new value in the same cycle.
    assign rd_data1 = (rd_addr1 == '0)                 ? '0      :
                      (wr.en && (wr.addr == rd_addr1)) ? wr.data :
                                                         regs[rd_addr1];

    assign rd_data2 = (rd_addr2 == '0)                 ? '0      :
                      (wr.en && (wr.addr == rd_addr2)) ? wr.data :
                                                         regs[rd_addr2];

endmodule

`default_nettype wire

// File: design/id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_stage_cfg.svh"

module id_ex_reg
    import id_stage_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  decoded_t dec,
    input  data_t    operand1,
    input  data_t    operand2,
    output id_ex_t   id_ex
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex.aluop    <= `ID_ALUOP_NOP;
            id_ex.alusel   <= `ID_ALUSEL_NOP;
            id_ex.operand1 <= '0;
            id_ex.operand2 <= '0;
            id_ex.wr_en    <= 1'b0;
            id_ex.wr_addr  <= '0;
        end else begin
            id_ex.aluop    <= dec.aluop;
            id_ex.alusel   <= dec.alusel;
            id_ex.operand1 <= operand1;
            id_ex.operand2 <= operand2;
            id_ex.wr_en    <= dec.wr_en;
            id_ex.wr_addr  <= dec.wr_addr;
        end
    end

endmodule

`default_nettype wire

// File: design/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage
    import id_stage_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  inst_t      inst,
    input  reg_write_t wb_write,
    input  reg_write_t ex_fwd,
    input  reg_write_t mem_fwd,
    output id_ex_t     id_ex
);

    decoded_t dec;
    data_t    rf_data1;
    data_t    rf_data2;
    data_t    operand1;
    data_t    operand2;

    id_decoder decoder_i (
        .inst (inst),
        .dec  (dec)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_addr1 (dec.rd_addr1),
        .rd_addr2 (dec.rd_addr2),
        .rd_data1 (rf_data1),
        .rd_data2 (rf_data2),
        .wr       (wb_write)
    );

    operand_forward fwd1_i (
        .rd_en   (dec.rd_en1),
        .rd_addr (dec.rd_addr1),
        .imm     (dec.imm),
        .rf_data (rf_data1),
        .ex_fwd  (ex_fwd),
        .mem_fwd (mem_fwd),
        .operand (operand1)
    );

    operand_forward fwd2_i (
        .rd_en   (dec.rd_en2),
        .rd_addr (dec.rd_addr2),
        .imm     (dec.imm),
        .rf_data (rf_data2),
        .ex_fwd  (ex_fwd),
        .mem_fwd (mem_fwd),
        .operand (operand2)
    );

    id_ex_reg id_ex_reg_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .dec      (dec),
        .operand1 (operand1),
        .operand2 (operand2),
        .id_ex    (id_ex)
    );

endmodule

`default_nettype wire

// File: testbench/id_stage_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_stage_cfg.svh"

module id_stage_checker
    import id_stage_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input id_ex_t id_ex
);

    int   error_count = 0;
    logic seen_edge = 1'b0;

    always @(posedge clk) begin
        seen_edge <= 1'b1;
    end

    // every reset edge reloads the NOP bundle, so nothing is written in the cycle after.
    reset_clears_wr_en: assert property (@(posedge clk)
        (seen_edge && !$past(rst_n)) |-> !id_ex.wr_en)
        else begin
            $error("id_ex write enable set after a reset edge");
            error_count++;
        end

    nop_writes_nothing: assert property (@(posedge clk) disable iff (!rst_n)
        (id_ex.aluop == `ID_ALUOP_NOP) |-> !id_ex.wr_en)
        else begin
            $error("id_ex carries a NOP with write enable set");
            error_count++;
        end

    alusel_defined: assert property (@(posedge clk) disable iff (!rst_n)
        id_ex.alusel inside {`ID_ALUSEL_NOP, `ID_ALUSEL_LOGIC, `ID_ALUSEL_SHIFT,
                             `ID_ALUSEL_ARITHMETIC})
        else begin
            $error("id_ex result select holds an undefined code");
            error_count++;
        end

endmodule

bind id_stage id_stage_checker checker_i (
    .clk   (clk),
    .rst_n (rst_n),
    .id_ex (id_ex)
);

`default_nettype wire

// File: testbench/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_stage_cfg.svh"

module tb_id_stage
    import id_stage_pkg::*;
();

    // opcode 0x3f is not decoded, so this word idles the stage.
    localparam inst_t IDLE_INST = 32'hFC00_0000;
    localparam id_ex_t NOP_BUNDLE = {`ID_ALUOP_NOP, `ID_ALUSEL_NOP, 32'h0, 32'h0, 1'b0, 5'h0};

    typedef struct {
        inst_t      inst;
        reg_write_t wb;
        reg_write_t ex;
        reg_write_t mem;
        id_ex_t     exp;
    } row_t;

    logic       clk;
    logic       rst_n;
    inst_t      inst;
    reg_write_t wb_write;
    reg_write_t ex_fwd;
    reg_write_t mem_fwd;
    id_ex_t     id_ex;

    row_t       rows [$];
    data_t      model [0:31];
    reg_write_t cur_wb;
    reg_write_t cur_ex;
    reg_write_t cur_mem;
    integer     seed;

    id_stage id_stage_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .inst     (inst),
        .wb_write (wb_write),
        .ex_fwd   (ex_fwd),
        .mem_fwd  (mem_fwd),
        .id_ex    (id_ex)
    );

    always #4 clk = ~clk;

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
    end

    task automatic stop_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // a failed assertion in the bound checker ends the run at the next falling edge.
    always @(negedge clk) begin
        if (id_stage_i.checker_i.error_count != 0) begin
            $display("an assertion in the checker failed");
            stop_run();
        end
    end

    task automatic check_aluop(string name, aluop_t exp, aluop_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_alusel(string name, alusel_t exp, alusel_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_data(string name, data_t exp, data_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_addr(string name, reg_addr_t exp, reg_addr_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_id_ex(string tag, id_ex_t exp);
        check_aluop({tag, " id_ex.aluop"}, exp.aluop, id_ex.aluop);
        check_alusel({tag, " id_ex.alusel"}, exp.alusel, id_ex.alusel);
        check_data({tag, " id_ex.operand1"}, exp.operand1, id_ex.operand1);
        check_data({tag, " id_ex.operand2"}, exp.operand2, id_ex.operand2);
        check_bit({tag, " id_ex.wr_en"}, exp.wr_en, id_ex.wr_en);
        check_addr({tag, " id_ex.wr_addr"}, exp.wr_addr, id_ex.wr_addr);
    endtask

    // a source register shows forwards before write-through and write-through before storage.
    function automatic data_t source_value(reg_addr_t addr);
        if (addr == '0) return '0;
        if (cur_ex.en && (cur_ex.addr == addr)) return cur_ex.data;
        if (cur_mem.en && (cur_mem.addr == addr)) return cur_mem.data;
        if (cur_wb.en && (cur_wb.addr == addr)) return cur_wb.data;
        return model[addr];
    endfunction

    task automatic add_row(inst_t word, aluop_t op, alusel_t sel, data_t op1, data_t op2,
                           logic wr_en, reg_addr_t wr_addr);
        row_t r;
        r.inst = word;
        r.wb   = cur_wb;
        r.ex   = cur_ex;
        r.mem  = cur_mem;
        r.exp  = {op, sel, op1, op2, wr_en, wr_addr};
        rows.push_back(r);
        if (cur_wb.en && (cur_wb.addr != '0)) model[cur_wb.addr] = cur_wb.data;
    endtask

    task automatic add_rform(logic [5:0] fn, aluop_t op, alusel_t sel,
                             reg_addr_t rs, reg_addr_t rt, reg_addr_t rd);
        add_row({6'b0, rs, rt, rd, 5'b0, fn}, op, sel, source_value(rs), source_value(rt),
                1'b1, rd);
    endtask

    task automatic add_shift(logic [5:0] fn, aluop_t op, reg_addr_t rt, reg_addr_t rd,
                             logic [4:0] sa);
        add_row({6'b0, 5'b0, rt, rd, sa, fn}, op, `ID_ALUSEL_SHIFT, {27'b0, sa},
                source_value(rt), 1'b1, rd);
    endtask

    task automatic add_iform(logic [5:0] opc, aluop_t op, alusel_t sel, reg_addr_t rs,
                             reg_addr_t rt, logic [15:0] im, data_t ext);
        add_row({opc, rs, rt, im}, op, sel, source_value(rs), ext, 1'b1, rt);
    endtask

    task automatic add_nop(inst_t word);
        add_row(word, `ID_ALUOP_NOP, `ID_ALUSEL_NOP, '0, '0, 1'b0, '0);
    endtask

    task build_table();
        add_rform(`ID_FN_OR, `ID_ALUOP_OR, `ID_ALUSEL_LOGIC, 5'd1, 5'd2, 5'd3);
        add_rform(`ID_FN_NOR, `ID_ALUOP_NOR, `ID_ALUSEL_LOGIC, 5'd4, 5'd5, 5'd6);
        add_rform(`ID_FN_ADDU, `ID_ALUOP_ADDU, `ID_ALUSEL_ARITHMETIC, 5'd7, 5'd8, 5'd9);
        add_rform(`ID_FN_SUB, `ID_ALUOP_SUB, `ID_ALUSEL_ARITHMETIC, 5'd10, 5'd11, 5'd12);
        add_rform(`ID_FN_SLT, `ID_ALUOP_SLT, `ID_ALUSEL_ARITHMETIC, 5'd13, 5'd14, 5'd15);
        add_rform(`ID_FN_SLTU, `ID_ALUOP_SLTU, `ID_ALUSEL_ARITHMETIC, 5'd16, 5'd17, 5'd18);
        // or with rs zero is a real instruction and must write rd.
        add_rform(`ID_FN_OR, `ID_ALUOP_OR, `ID_ALUSEL_LOGIC, 5'd0, 5'd19, 5'd20);

        add_iform(`ID_OP_ANDI, `ID_ALUOP_AND, `ID_ALUSEL_LOGIC, 5'd5, 5'd21,
                  16'hF0F0, 32'h0000_F0F0);
        add_iform(`ID_OP_XORI, `ID_ALUOP_XOR, `ID_ALUSEL_LOGIC, 5'd6, 5'd22,
                  16'h8001, 32'h0000_8001);
        add_iform(`ID_OP_ADDIU, `ID_ALUOP_ADDIU, `ID_ALUSEL_ARITHMETIC, 5'd7, 5'd23,
                  16'hFFF0, 32'hFFFF_FFF0);
        add_iform(`ID_OP_SLTI, `ID_ALUOP_SLT, `ID_ALUSEL_ARITHMETIC, 5'd8, 5'd24,
                  16'h8000, 32'hFFFF_8000);
        add_iform(`ID_OP_LUI, `ID_ALUOP_OR, `ID_ALUSEL_LOGIC, 5'd0, 5'd25,
                  16'hABCD, 32'hABCD_0000);

        add_shift(`ID_FN_SLL, `ID_ALUOP_SLL, 5'd9, 5'd26, 5'd5);
        add_shift(`ID_FN_SRA, `ID_ALUOP_SRA, 5'd10, 5'd27, 5'd31);
        add_rform(`ID_FN_SRLV, `ID_ALUOP_SRL, `ID_ALUSEL_SHIFT, 5'd11, 5'd12, 5'd28);

        cur_ex  = {1'b1, 5'd1, 32'hEEEE_0001};
        cur_mem = {1'b1, 5'd1, 32'hAAAA_0001};
        add_rform(`ID_FN_OR, `ID_ALUOP_OR, `ID_ALUSEL_LOGIC, 5'd1, 5'd2, 5'd3);
        cur_ex  = '0;
        cur_mem = {1'b1, 5'd2, 32'hAAAA_0002};
        add_rform(`ID_FN_ADDU, `ID_ALUOP_ADDU, `ID_ALUSEL_ARITHMETIC, 5'd1, 5'd2, 5'd4);
        cur_ex  = {1'b0, 5'd2, 32'hEEEE_0002};
        cur_mem = '0;
        add_rform(`ID_FN_SUBU, `ID_ALUOP_SUBU, `ID_ALUSEL_ARITHMETIC, 5'd2, 5'd1, 5'd5);
        cur_ex  = {1'b1, 5'd0, 32'hEEEE_0000};
        cur_mem = {1'b1, 5'd0, 32'hAAAA_0000};
        add_rform(`ID_FN_XOR, `ID_ALUOP_XOR, `ID_ALUSEL_LOGIC, 5'd0, 5'd3, 5'd6);
        cur_ex  = '0;
        cur_mem = '0;
        cur_wb  = {1'b1, 5'd13, 32'h1234_5678};
        add_rform(`ID_FN_AND, `ID_ALUOP_AND, `ID_ALUSEL_LOGIC, 5'd13, 5'd14, 5'd7);
        cur_wb  = '0;
        add_rform(`ID_FN_AND, `ID_ALUOP_AND, `ID_ALUSEL_LOGIC, 5'd13, 5'd13, 5'd8);

        add_nop(32'hFC21_1801);
        add_nop(32'h8C22_0004);
        add_nop({6'b0, 5'd1, 5'd2, 5'd3, 5'd4, `ID_FN_ADDU});
        add_nop({6'b0, 5'd1, 5'd2, 5'd3, 5'd4, `ID_FN_SLL});
    endtask

    initial begin
        int   waited;
        logic released;
        clk      = 1'b0;
        inst     = IDLE_INST;
        wb_write = '0;
        ex_fwd   = '0;
        mem_fwd  = '0;
        cur_wb   = '0;
        cur_ex   = '0;
        cur_mem  = '0;
        seed     = 20;

        waited   = 0;
        released = 1'b0;
        while (!released) begin
            @(posedge clk);
            released = rst_n;
            #1;
            check_id_ex($sformatf("reset cycle %0d", waited), NOP_BUNDLE);
            waited++;
            if (!released && (waited >= 20)) begin
                $display("reset was not released within 20 clock cycles");
                stop_run();
            end
        end

        // preload every writable register through the write-back port.
        for (int k = 1; k < 32; k++) begin
            wb_write.en   = 1'b1;
            wb_write.addr = reg_addr_t'(k);
            wb_write.data = $random(seed);
            model[k]      = wb_write.data;
            @(posedge clk);
            #1;
            check_id_ex($sformatf("preload %0d", k), NOP_BUNDLE);
        end
        wb_write = '0;

        build_table();
        foreach (rows[i]) begin
            inst     = rows[i].inst;
            wb_write = rows[i].wb;
            ex_fwd   = rows[i].ex;
            mem_fwd  = rows[i].mem;
            @(posedge clk);
            #1;
            check_id_ex($sformatf("row %0d", i), rows[i].exp);
        end

        inst     = IDLE_INST;
        wb_write = '0;
        ex_fwd   = '0;
        mem_fwd  = '0;
        @(posedge clk);
        #1;
        check_id_ex("idle", NOP_BUNDLE);

        if (id_stage_i.checker_i.error_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("the checker reported %0d assertion failures",
                     id_stage_i.checker_i.error_count);
            stop_run();
        end
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
design/id_stage_pkg.sv
design/id_decoder.sv
design/operand_forward.sv
design/reg_file.sv
design/id_ex_reg.sv
design/id_stage.sv
testbench/id_stage_checker.sv
testbench/tb_id_stage.sv

// File: Bender.yml
package:
  name: id_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/id_stage_pkg.sv
      - design/id_decoder.sv
      - design/operand_forward.sv
      - design/reg_file.sv
      - design/id_ex_reg.sv
      - design/id_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/id_stage_checker.sv
      - testbench/tb_id_stage.sv
